/* common/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ----------------------------------------------------------------------
// Fetch unit widths
// ----------------------------------------------------------------------

// Program counter width
`define FETCH_PC_WD 32

// Instruction word width, RV32I without compressed forms
`define FETCH_INST_WD 32

// ----------------------------------------------------------------------
// Reset vector
// ----------------------------------------------------------------------

// First fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

// Sequential step between instructions
`define FETCH_PC_STEP 4

`endif

/* common/fetch_if.sv */
`include "fetch_config.svh"

// Strobes from the controller and the next fetch address back
interface fetch_if ();

    // Wanted response arrived, take the item PC
    logic capture;

    // Fetch PC moves on to the next request
    logic advance;

    // Flush seen this cycle
    logic redirect;

    logic [`FETCH_PC_WD-1:0] fetch_pc;

    modport ctrl (
        output capture,
        output advance,
        output redirect
    );

    modport pc (
        input  capture,
        input  advance,
        input  redirect,
        output fetch_pc
    );

endinterface

/* common/fetch_pkg.sv */
package fetch_pkg;

    // ------------------------------------------------------------------
    // Fetch controller states
    // ------------------------------------------------------------------

    // One request in flight at most
    // DROP_* states collect a response that a flush made stale
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        REQUEST   = 3'd1,
        WAIT_RESP = 3'd2,
        HOLD      = 3'd3,
        DROP_REQ  = 3'd4,
        DROP_RESP = 3'd5
    } fetch_state_t;

    // ------------------------------------------------------------------
    // Control kind of the held instruction
    // ------------------------------------------------------------------

    typedef enum logic [3:0] {
        CK_NONE = 4'd0,
        CK_JAL  = 4'd1,
        CK_JALR = 4'd2,
        CK_BEQ  = 4'd3,
        CK_BNE  = 4'd4,
        CK_BLT  = 4'd5,
        CK_BGE  = 4'd6,
        CK_BLTU = 4'd7,
        CK_BGEU = 4'd8
    } ctrl_kind_t;

    // ------------------------------------------------------------------
    // Major opcodes seen by the predecoder
    // ------------------------------------------------------------------

    // Only control transfers matter here
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011
    } opcode_t;

endpackage

/* common/predecode_if.sv */
`include "fetch_config.svh"

// Held item and its static prediction
interface predecode_if import fetch_pkg::*; ();

    logic [`FETCH_INST_WD-1:0] inst;
    logic [`FETCH_PC_WD-1:0]   item_pc;
    ctrl_kind_t                kind;
    logic                      pred_taken;
    logic [`FETCH_PC_WD-1:0]   pred_target;

    // fetch_ctrl owns the instruction word
    modport source (
        output inst
    );

    // pc_gen owns the item PC and consumes the prediction
    modport pc (
        output item_pc,
        input  pred_taken,
        input  pred_target
    );

    modport decoder (
        input  inst,
        input  item_pc,
        output kind,
        output pred_taken,
        output pred_target
    );

endinterface

/* fetch/fetch_ctrl.sv */
`include "fetch_config.svh"

module fetch_ctrl import fetch_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      ds_allowin,
    input  logic                      inst_ready,
    input  logic                      inst_valid,
    input  logic [`FETCH_INST_WD-1:0] inst_rdata,
    output logic                      inst_en,
    output logic                      fs_to_ds_valid,
    fetch_if.ctrl                     fe,
    predecode_if.source               pd
);

    fetch_state_t              state;
    fetch_state_t              state_nxt;
    logic                      item_valid;
    logic                      accept;
    logic                      restart;
    logic [`FETCH_INST_WD-1:0] inst_q;

    // ------------------------------------------------------------------
    // Handshake terms
    // ------------------------------------------------------------------

    // Decode takes the held item
    assign accept = item_valid && ds_allowin;

    // Request level covers the stale request too, it must still be accepted
    assign inst_en = (state == REQUEST) || (state == DROP_REQ);

    // ------------------------------------------------------------------
    // Request / response sequencing
    // ------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        restart   = 1'b0;
        case (state)
            IDLE: begin
                state_nxt = REQUEST;
                restart   = flush;
            end
            REQUEST: begin
                if (inst_ready) begin
                    // Accepted in a flush cycle, its response is owed
                    state_nxt = flush ? DROP_RESP : WAIT_RESP;
                end else if (flush) begin
                    state_nxt = DROP_REQ;
                end
            end
            WAIT_RESP: begin
                if (flush) begin
                    if (inst_valid) begin
                        // Stale data arrives with the flush, nothing left owed
                        state_nxt = REQUEST;
                        restart   = 1'b1;
                    end else begin
                        state_nxt = DROP_RESP;
                    end
                end else if (inst_valid) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (flush) begin
                    state_nxt = REQUEST;
                    restart   = 1'b1;
                end else if (ds_allowin) begin
                    state_nxt = REQUEST;
                end
            end
            DROP_REQ: begin
                if (inst_ready) begin
                    state_nxt = DROP_RESP;
                end
            end
            DROP_RESP: begin
                if (inst_valid) begin
                    state_nxt = REQUEST;
                    restart   = 1'b1;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // Strobes to pc_gen
    // ------------------------------------------------------------------

    assign fe.capture  = (state == WAIT_RESP) && inst_valid && !flush;
    assign fe.redirect = flush;

    // Restart after a flush uses the redirect target inside pc_gen
    assign fe.advance  = (accept && !flush) || restart;

    // ------------------------------------------------------------------
    // Held item
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
        end else if (fe.capture) begin
            item_valid <= 1'b1;
        end else if (accept || flush) begin
            item_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe.capture) begin
            inst_q <= inst_rdata;
        end
    end

    assign pd.inst        = inst_q;
    assign fs_to_ds_valid = item_valid;

endmodule

/* fetch/pc_gen.sv */
`include "fetch_config.svh"

module pc_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`FETCH_PC_WD-1:0] flush_pc,
    input  logic                    flush_pc_p4,
    fetch_if.pc                     fe,
    predecode_if.pc                 pd
);

    logic [`FETCH_PC_WD-1:0] fetch_pc_q;
    logic [`FETCH_PC_WD-1:0] item_pc_q;
    logic [`FETCH_PC_WD-1:0] redir_pc;
    logic                    redir_pend;
    logic [`FETCH_PC_WD-1:0] redir_tgt;
    logic [`FETCH_PC_WD-1:0] pred_pc;

    // ------------------------------------------------------------------
    // Candidate addresses
    // ------------------------------------------------------------------

    // Flush target, optionally past the flushing instruction
    assign redir_tgt = flush_pc_p4 ? flush_pc + `FETCH_PC_STEP : flush_pc;

    // Not taken falls through to the sequential address
    assign pred_pc = pd.pred_taken ? pd.pred_target : item_pc_q + `FETCH_PC_STEP;

    // ------------------------------------------------------------------
    // Fetch PC and pending redirect
    // ------------------------------------------------------------------

    // A redirect with no advance waits for the stale response,
    // so the request on the bus keeps its address meanwhile
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc_q <= `FETCH_RESET_PC;
            redir_pend <= 1'b0;
        end else if (fe.redirect) begin
            if (fe.advance) begin
                fetch_pc_q <= redir_tgt;
            end
            redir_pend <= !fe.advance;
        end else if (fe.advance) begin
            fetch_pc_q <= redir_pend ? redir_pc : pred_pc;
            redir_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe.redirect) begin
            redir_pc <= redir_tgt;
        end
    end

    // ------------------------------------------------------------------
    // Held item PC
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (fe.capture) begin
            item_pc_q <= fetch_pc_q;
        end
    end

    assign fe.fetch_pc = fetch_pc_q;
    assign pd.item_pc  = item_pc_q;

endmodule

/* hw/ifu_top.sv */
`include "fetch_config.svh"

module ifu_top import fetch_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,

    // Decode side
    input  logic                      ds_allowin,
    output logic                      fs_to_ds_valid,
    output logic [`FETCH_INST_WD-1:0] fs_to_ds_inst,
    output logic [`FETCH_PC_WD-1:0]   fs_to_ds_pc,
    output ctrl_kind_t                fs_to_ds_kind,
    output logic                      fs_to_ds_pred_taken,
    output logic [`FETCH_PC_WD-1:0]   fs_to_ds_pred_target,

    // Instruction memory
    output logic                      inst_en,
    input  logic                      inst_ready,
    output logic [`FETCH_PC_WD-1:0]   inst_addr,
    input  logic [`FETCH_INST_WD-1:0] inst_rdata,
    input  logic                      inst_valid,

    // jalr base and flush redirect
    input  logic [`FETCH_PC_WD-1:0]   ra_data,
    input  logic                      flush,
    input  logic [`FETCH_PC_WD-1:0]   flush_pc,
    input  logic                      flush_pc_p4
);

    predecode_if pd ();
    fetch_if     fe ();

    fetch_ctrl u_fetch_ctrl (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .inst_ready     (inst_ready),
        .inst_valid     (inst_valid),
        .inst_rdata     (inst_rdata),
        .inst_en        (inst_en),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fe             (fe.ctrl),
        .pd             (pd.source)
    );

    pc_gen u_pc_gen (
        .clk         (clk),
        .reset       (reset),
        .flush_pc    (flush_pc),
        .flush_pc_p4 (flush_pc_p4),
        .fe          (fe.pc),
        .pd          (pd.pc)
    );

    pre_decoder u_pre_decoder (
        .ra_data (ra_data),
        .pd      (pd.decoder)
    );

    // Held item straight out to decode
    assign inst_addr            = fe.fetch_pc;
    assign fs_to_ds_inst        = pd.inst;
    assign fs_to_ds_pc          = pd.item_pc;
    assign fs_to_ds_kind        = pd.kind;
    assign fs_to_ds_pred_taken  = pd.pred_taken;
    assign fs_to_ds_pred_target = pd.pred_target;

endmodule

/* hw/pre_decoder.sv */
`include "fetch_config.svh"

module pre_decoder import fetch_pkg::*; (
    input  logic [`FETCH_PC_WD-1:0] ra_data,
    predecode_if.decoder            pd
);

    opcode_t                 opcode;
    logic [2:0]              funct3;
    logic [`FETCH_PC_WD-1:0] imm_b;
    logic [`FETCH_PC_WD-1:0] imm_i;
    logic [`FETCH_PC_WD-1:0] imm_j;
    logic [`FETCH_PC_WD-1:0] tgt_base;
    logic [`FETCH_PC_WD-1:0] tgt_off;
    logic                    is_branch;

    assign opcode = opcode_t'(pd.inst[6:0]);
    assign funct3 = pd.inst[14:12];

    // ------------------------------------------------------------------
    // Immediates, sign extended
    // ------------------------------------------------------------------

    assign imm_b = {{20{pd.inst[31]}}, pd.inst[7], pd.inst[30:25], pd.inst[11:8], 1'b0};
    assign imm_i = {{20{pd.inst[31]}}, pd.inst[31:20]};
    assign imm_j = {{12{pd.inst[31]}}, pd.inst[19:12], pd.inst[20], pd.inst[30:21], 1'b0};

    // ------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------

    always_comb begin
        pd.kind = CK_NONE;
        case (opcode)
            OP_JAL:  pd.kind = CK_JAL;
            OP_JALR: pd.kind = CK_JALR;
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  pd.kind = CK_BEQ;
                    3'b001:  pd.kind = CK_BNE;
                    3'b100:  pd.kind = CK_BLT;
                    3'b101:  pd.kind = CK_BGE;
                    3'b110:  pd.kind = CK_BLTU;
                    3'b111:  pd.kind = CK_BGEU;
                    // funct3 010 and 011 are not branches
                    default: pd.kind = CK_NONE;
                endcase
            end
            default: pd.kind = CK_NONE;
        endcase
    end

    assign is_branch = (pd.kind != CK_NONE) && (pd.kind != CK_JAL) && (pd.kind != CK_JALR);

    // ------------------------------------------------------------------
    // Static prediction
    // ------------------------------------------------------------------

    // Backward branches are assumed to close a loop
    assign pd.pred_taken = (pd.kind == CK_JAL) || (pd.kind == CK_JALR)
                         || (is_branch && imm_b[`FETCH_PC_WD-1]);

    // One adder serves every kind
    always_comb begin
        tgt_base = pd.item_pc;
        tgt_off  = `FETCH_PC_STEP;
        if (pd.kind == CK_JAL) begin
            tgt_off = imm_j;
        end else if (pd.kind == CK_JALR) begin
            tgt_base = ra_data;
            tgt_off  = imm_i;
        end else if (is_branch) begin
            tgt_off = imm_b;
        end
    end

    assign pd.pred_target = tgt_base + tgt_off;

endmodule

/* tb.f */
+incdir+common
common/fetch_pkg.sv
common/predecode_if.sv
common/fetch_if.sv
fetch/fetch_ctrl.sv
fetch/pc_gen.sv
hw/pre_decoder.sv
hw/ifu_top.sv
test/imem_model.sv
test/ifu_tb.sv

/* test/ifu_tb.sv */
`include "fetch_config.svh"

module ifu_tb import fetch_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BASE = `FETCH_RESET_PC;

    logic clk, reset, ds_allowin, inst_ready, inst_valid, inst_en, flush, flush_pc_p4;
    logic fs_to_ds_valid, fs_to_ds_pred_taken, proto_err;
    logic [31:0] inst_rdata, inst_addr, ra_data, flush_pc;
    logic [31:0] fs_to_ds_inst, fs_to_ds_pc, fs_to_ds_pred_target;
    ctrl_kind_t  fs_to_ds_kind;

    // Scoreboard state
    logic        deliver, en_d, held_d, hold_req_d, pend_item, req_seen = 1'b0;
    logic [31:0] expect_addr, item_pc_exp, pc_d, inst_d, addr_d;

    ifu_top uut (.*);

    imem_model imem (.clk(clk), .reset(reset), .inst_en(inst_en), .inst_addr(inst_addr),
        .inst_ready(inst_ready), .inst_valid(inst_valid), .inst_rdata(inst_rdata),
        .proto_err(proto_err));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference prediction
    // ------------------------------------------------------------------

    function automatic ctrl_kind_t classify_inst(input logic [31:0] w);
        if (w[6:0] == 7'h6f) return CK_JAL;
        if (w[6:0] == 7'h67) return CK_JALR;
        if (w[6:0] != 7'h63) return CK_NONE;
        case (w[14:12])
            3'd0:    return CK_BEQ;
            3'd1:    return CK_BNE;
            3'd4:    return CK_BLT;
            3'd5:    return CK_BGE;
            3'd6:    return CK_BLTU;
            3'd7:    return CK_BGEU;
            default: return CK_NONE;
        endcase
    endfunction

    // Branch offset sign sits in bit 31
    function automatic logic is_taken(input logic [31:0] w);
        ctrl_kind_t k;
        k = classify_inst(w);
        return (k == CK_JAL) || (k == CK_JALR) || ((k != CK_NONE) && w[31]);
    endfunction

    function automatic logic [31:0] target_of(input logic [31:0] w, input logic [31:0] pc);
        case (classify_inst(w))
            CK_NONE: return pc + 32'd4;
            CK_JAL:  return pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            CK_JALR: return ra_data + {{20{w[31]}}, w[31:20]};
            default: return pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp, act);
        fail_run($sformatf("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    endtask

    // ------------------------------------------------------------------
    // Expected values updated on each edge
    // ------------------------------------------------------------------

    assign deliver = fs_to_ds_valid && ds_allowin && !flush;

    always @(posedge clk) begin
        en_d       <= inst_en;
        held_d     <= fs_to_ds_valid && !ds_allowin && !flush;
        hold_req_d <= inst_en && !inst_ready;
        pc_d       <= fs_to_ds_pc;
        inst_d     <= fs_to_ds_inst;
        addr_d     <= inst_addr;
        if (inst_en && inst_ready && !reset) req_seen <= 1'b1;
        if (reset) begin
            expect_addr <= BASE;
            pend_item   <= 1'b0;
        end else if (flush) begin
            expect_addr <= flush_pc_p4 ? flush_pc + 32'd4 : flush_pc;
            item_pc_exp <= flush_pc_p4 ? flush_pc + 32'd4 : flush_pc;
            pend_item   <= 1'b1;
        end else if (deliver) begin
            expect_addr <= is_taken(fs_to_ds_inst) ? target_of(fs_to_ds_inst, fs_to_ds_pc)
                                                   : fs_to_ds_pc + 32'd4;
            pend_item   <= 1'b0;
        end
    end

    // Random back-pressure from decode
    always @(posedge clk) begin
        ds_allowin <= reset ? 1'b0 : ($urandom_range(3, 0) != 0);
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    assert property (@(posedge clk) reset |=> !inst_en && !fs_to_ds_valid)
        else fail_run("request or item valid was high during reset");
    assert property (@(posedge clk) !proto_err)
        else fail_run("instruction request raised while a response was still owed");
    assert property (@(posedge clk) disable iff (reset) inst_en && inst_ready && !req_seen
                     |-> inst_addr == BASE)
        else report_mismatch("inst_addr", BASE, $sampled(inst_addr));
    assert property (@(posedge clk) disable iff (reset) inst_en && !en_d
                     |-> inst_addr == expect_addr)
        else report_mismatch("inst_addr", $sampled(expect_addr), $sampled(inst_addr));
    assert property (@(posedge clk) disable iff (reset) hold_req_d |-> inst_en)
        else fail_run("request dropped before it was accepted");
    assert property (@(posedge clk) disable iff (reset) hold_req_d |-> inst_addr == addr_d)
        else report_mismatch("inst_addr", $sampled(addr_d), $sampled(inst_addr));
    assert property (@(posedge clk) disable iff (reset) fs_to_ds_valid |-> !inst_en)
        else fail_run("new request made while an item was held");
    assert property (@(posedge clk) disable iff (reset) held_d |-> fs_to_ds_valid)
        else fail_run("held item withdrawn before decode took it");
    assert property (@(posedge clk) disable iff (reset) held_d |-> fs_to_ds_pc == pc_d)
        else report_mismatch("fs_to_ds_pc", $sampled(pc_d), $sampled(fs_to_ds_pc));
    assert property (@(posedge clk) disable iff (reset) held_d |-> fs_to_ds_inst == inst_d)
        else report_mismatch("fs_to_ds_inst", $sampled(inst_d), $sampled(fs_to_ds_inst));
    assert property (@(posedge clk) disable iff (reset) flush |=> !fs_to_ds_valid)
        else fail_run("item still valid in the cycle after a flush");
    assert property (@(posedge clk) disable iff (reset) deliver && pend_item
                     |-> fs_to_ds_pc == item_pc_exp)
        else report_mismatch("fs_to_ds_pc", $sampled(item_pc_exp), $sampled(fs_to_ds_pc));
    assert property (@(posedge clk) disable iff (reset) deliver
                     |-> fs_to_ds_inst == imem.word_at(fs_to_ds_pc))
        else report_mismatch("fs_to_ds_inst", imem.word_at($sampled(fs_to_ds_pc)),
                             $sampled(fs_to_ds_inst));
    assert property (@(posedge clk) disable iff (reset) deliver
                     |-> fs_to_ds_kind == classify_inst(fs_to_ds_inst))
        else report_mismatch("fs_to_ds_kind", classify_inst($sampled(fs_to_ds_inst)),
                             $sampled(fs_to_ds_kind));
    assert property (@(posedge clk) disable iff (reset) deliver
                     |-> fs_to_ds_pred_taken == is_taken(fs_to_ds_inst))
        else report_mismatch("fs_to_ds_pred_taken", is_taken($sampled(fs_to_ds_inst)),
                             $sampled(fs_to_ds_pred_taken));
    assert property (@(posedge clk) disable iff (reset) deliver
                     |-> fs_to_ds_pred_target == target_of(fs_to_ds_inst, fs_to_ds_pc))
        else report_mismatch("fs_to_ds_pred_target",
                             target_of($sampled(fs_to_ds_inst), $sampled(fs_to_ds_pc)),
                             $sampled(fs_to_ds_pred_target));

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    task automatic wait_items(input int n);
        int count;
        int cycles;
        count  = 0;
        cycles = 0;
        while (count < n) begin
            @(posedge clk);
            if (deliver) count++;
            cycles++;
            if (cycles > 60 * n) fail_run("timed out waiting for items to reach decode");
        end
    endtask

    // Flush lands in the cycle where the controller is in state st
    task automatic flush_in_state(input fetch_state_t st, input logic [31:0] pc,
                                  input logic p4);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (uut.u_fetch_ctrl.state_nxt != st) begin
            cycles++;
            if (cycles > 200) fail_run("timed out waiting for the fetch state to flush in");
            @(posedge clk);
        end
        flush       <= 1'b1;
        flush_pc    <= pc;
        flush_pc_p4 <= p4;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h940d_b4aa));
        reset       = 1'b1;
        ds_allowin  = 1'b0;
        flush       = 1'b0;
        flush_pc    = '0;
        flush_pc_p4 = 1'b0;
        ra_data     = BASE;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_items(8);
        flush_in_state(REQUEST, BASE + 32'd12, 1'b1);
        wait_items(8);
        flush_in_state(WAIT_RESP, BASE + 32'h100, 1'b0);
        wait_items(5);
        flush_in_state(HOLD, BASE + 32'd24, 1'b1);
        wait_items(6);
        flush_in_state(REQUEST, BASE + 32'd28, 1'b0);
        wait_items(4);
        // Second reset so that a flush meets the idle state
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset       <= 1'b0;
        flush       <= 1'b1;
        flush_pc    <= BASE + 32'd32;
        flush_pc_p4 <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        wait_items(6);
        $display("** PASS **");
        $finish;
    end

endmodule

/* test/imem_model.sv */
`include "fetch_config.svh"

// Instruction memory with random ready and response delays
module imem_model (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_en,
    input  logic [`FETCH_PC_WD-1:0]   inst_addr,
    output logic                      inst_ready,
    output logic                      inst_valid,
    output logic [`FETCH_INST_WD-1:0] inst_rdata,
    output logic                      proto_err
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                    owed;
    logic [`FETCH_PC_WD-1:0] addr_q;
    int unsigned             ready_cnt;
    int unsigned             resp_cnt;

    // Program table holding one word per address from the reset PC
    function automatic logic [`FETCH_INST_WD-1:0] word_at(input logic [`FETCH_PC_WD-1:0] addr);
        logic [`FETCH_PC_WD-1:0] idx;
        idx = (addr - `FETCH_RESET_PC) >> 2;
        case (idx)
            0:       return 32'h0010_0093;  // addi x1, x0, 1
            1:       return 32'h0030_0113;  // addi x2, x0, 3
            2:       return 32'h0010_8093;  // loop: addi x1, x1, 1
            3:       return 32'hfe00_0ee3;  // beq x0, x0, loop
            4:       return 32'h00c0_006f;  // jal x0, +12
            5:       return 32'h0050_0193;  // addi x3, x0, 5
            6:       return 32'h0060_0213;  // addi x4, x0, 6
            7:       return 32'h0020_9463;  // bne x1, x2, +8
            8:       return 32'h0042_8067;  // jalr x0, 4(x5)
            default: return 32'h0000_0013;  // nop
        endcase
    endfunction

    // Quiet bus before the first clock edge
    initial begin
        inst_ready <= 1'b0;
        inst_valid <= 1'b0;
        inst_rdata <= '0;
        proto_err  <= 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            inst_ready <= 1'b0;
            inst_valid <= 1'b0;
            inst_rdata <= '0;
            owed       <= 1'b0;
            proto_err  <= 1'b0;
            ready_cnt  <= 0;
            resp_cnt   <= 0;
        end else begin
            inst_valid <= 1'b0;
            if (inst_en && owed) begin
                proto_err <= 1'b1;
            end
            if (inst_en && inst_ready) begin
                owed       <= 1'b1;
                addr_q     <= inst_addr;
                resp_cnt   <= $urandom_range(3, 0);
                ready_cnt  <= $urandom_range(3, 0);
                inst_ready <= 1'b0;
            end else if (owed) begin
                if (resp_cnt == 0) begin
                    inst_valid <= 1'b1;
                    inst_rdata <= word_at(addr_q);
                    owed       <= 1'b0;
                end else begin
                    resp_cnt <= resp_cnt - 1;
                end
            end else if (ready_cnt == 0) begin
                // Ready may already be up when the request rises
                inst_ready <= 1'b1;
            end else begin
                ready_cnt <= ready_cnt - 1;
            end
        end
    end

endmodule
